// ==== design/conv_cfg.svh ====
`ifndef CONV_CFG_SVH
`define CONV_CFG_SVH

// Core geometry
`define CONV_SA_ROWS     4      // Array rows, also output channels per row
`define CONV_PE_ROWS     16     // PE rows in one array
`define CONV_LANES       2      // Pixel or weight lanes per channel

// Bias storage
`define CONV_BIAS_W      8      // One 8-bit bias, also the output pixel width
`define CONV_BIAS_SET_W  16     // Two biases or one wide bias
`define CONV_TILE_W      1024   // 64 sets of 16 bits

// Datapath
`define CONV_PSUM_W      24     // Partial sum per lane
`define CONV_ACC_W       25     // One bit of headroom for the bias add
`define CONV_ROW_IDX_W   5      // One-based row index, 0 means no bias
`define CONV_SHIFT_W     5      // Requant shift amount

`endif

// ==== design/conv_pkg.sv ====
`default_nettype none

package conv_pkg;

    `include "conv_cfg.svh"

    ////////////////////////////////////////////////////////////
    // Lane scalars
    ////////////////////////////////////////////////////////////

    typedef logic signed [`CONV_BIAS_W-1:0]     bias_t;  // 1x8 bias, one per weight lane
    typedef logic signed [`CONV_BIAS_SET_W-1:0] bias16_t; // 8x8 bias, shared by lanes
    typedef logic signed [`CONV_PSUM_W-1:0]     psum_t;
    typedef logic signed [`CONV_ACC_W-1:0]      acc_t;
    typedef logic signed [`CONV_BIAS_W-1:0]     pix_t;   // Saturated int8 result

    // Array mode, picks how a bias set is read
    typedef enum logic {
        MODE_88 = 1'b0,  // 8x8, two pixel lanes, one weight
        MODE_18 = 1'b1   // 1x8, two weight lanes
    } mode_e;

    ////////////////////////////////////////////////////////////
    // Bias set, one 16-bit word decoded two ways
    ////////////////////////////////////////////////////////////

    typedef union packed {
        bias16_t                   bias88;  // Whole word, sign-extended per lane
        bias_t [`CONV_LANES-1:0]   bias18;  // Byte k belongs to lane k
    } bias_set_u;

    // Four channel sets, channel 0 in the low bits
    typedef bias_set_u [`CONV_SA_ROWS-1:0] bias_row_t;

    ////////////////////////////////////////////////////////////
    // Row vectors, [channel][lane]
    ////////////////////////////////////////////////////////////

    typedef psum_t [`CONV_SA_ROWS-1:0][`CONV_LANES-1:0] psum_row_t;
    typedef acc_t  [`CONV_SA_ROWS-1:0][`CONV_LANES-1:0] acc_row_t;
    typedef pix_t  [`CONV_SA_ROWS-1:0][`CONV_LANES-1:0] pix_row_t;

endpackage

`default_nettype wire

// ==== design/acc_if.sv ====
`default_nettype none

`include "conv_cfg.svh"

// Biased accumulator row between the two pipeline stages
interface acc_if;

    import conv_pkg::*;

    logic                       valid;    // One transfer per high cycle, no stall
    logic [`CONV_ROW_IDX_W-1:0] row_idx;  // Travels with the data
    mode_e                      mode;     // Mode of the sampled row
    acc_row_t                   acc;      // Partial sum plus bias

    // Producer side, bias_align
    modport src (output valid, output row_idx, output mode, output acc);

    // Consumer side, requantizer
    modport dst (input valid, input row_idx, input mode, input acc);

endinterface

`default_nettype wire

// ==== design/bias_bank.sv ====
`default_nettype none

`include "conv_cfg.svh"

module bias_bank (
    input  wire logic                       clk,
    input  wire logic                       arst_n,
    input  wire logic                       set,       // Load whole tile
    input  wire logic [`CONV_TILE_W-1:0]    tile_val,
    input  wire logic [`CONV_ROW_IDX_W-1:0] row_idx,   // One-based, 0 gives zero bias
    output conv_pkg::bias_row_t             bias_row
);

    import conv_pkg::*;

    localparam int PE_IDX_W = $clog2(`CONV_PE_ROWS);

    // [channel][pe row]
    bias_set_u tile [`CONV_SA_ROWS][`CONV_PE_ROWS];

    logic [PE_IDX_W-1:0] rd_row;
    logic                rd_hit;

    ////////////////////////////////////////////////////////////
    // Tile load
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int c = 0; c < `CONV_SA_ROWS; c++) begin
                for (int r = 0; r < `CONV_PE_ROWS; r++) begin
                    tile[c][r] <= '0;  // Tile reads zero until first load
                end
            end
        end else if (set) begin
            for (int c = 0; c < `CONV_SA_ROWS; c++) begin
                for (int r = 0; r < `CONV_PE_ROWS; r++) begin
                    // Channel-major, set index c*16 + r
                    tile[c][r] <= tile_val[(c*`CONV_PE_ROWS + r)*`CONV_BIAS_SET_W
                                           +: `CONV_BIAS_SET_W];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Combinational read
    ////////////////////////////////////////////////////////////

    assign rd_row = PE_IDX_W'(row_idx - 1'b1);  // Drop the one-based offset
    assign rd_hit = (row_idx != '0) && (row_idx <= `CONV_PE_ROWS);

    always_comb begin
        for (int c = 0; c < `CONV_SA_ROWS; c++) begin
            bias_row[c] = '0;                      // Row 0 or out of range
            if (rd_hit) begin
                bias_row[c] = tile[c][rd_row];
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/bias_align.sv ====
`default_nettype none

`include "conv_cfg.svh"

// Stage 1: pick the bias per lane and add it to the partial sum
module bias_align (
    input  wire logic                       clk,
    input  wire logic                       arst_n,
    input  wire logic                       psum_valid,
    input  wire logic [`CONV_ROW_IDX_W-1:0] psum_row_idx,
    input  conv_pkg::psum_row_t             psum_data,
    input  conv_pkg::mode_e                 mode,
    output logic [`CONV_ROW_IDX_W-1:0]      bias_idx,   // To bank, read same cycle
    input  conv_pkg::bias_row_t             bias_row,
    acc_if.src                              acc
);

    import conv_pkg::*;

    acc_row_t sum;  // Next accumulator row

    // Bank lookup follows the incoming row directly
    assign bias_idx = psum_row_idx;

    ////////////////////////////////////////////////////////////
    // Mode decode and add
    ////////////////////////////////////////////////////////////

    always_comb begin
        acc_t bias_lane;
        for (int c = 0; c < `CONV_SA_ROWS; c++) begin
            for (int l = 0; l < `CONV_LANES; l++) begin
                if (mode == MODE_88) begin
                    bias_lane = bias_row[c].bias88;     // Shared 16-bit bias
                end else begin
                    bias_lane = bias_row[c].bias18[l];  // Own byte per weight lane
                end
                // Sign extension from both operands, 25 bits cannot overflow
                sum[c][l] = psum_data[c][l] + bias_lane;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stage register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc.valid <= 1'b0;
        end else begin
            acc.valid <= psum_valid;
        end
    end

    // Payload only moves with a valid item
    always_ff @(posedge clk) begin
        if (psum_valid) begin
            acc.row_idx <= psum_row_idx;
            acc.mode    <= mode;
            acc.acc     <= sum;
        end
    end

endmodule

`default_nettype wire

// ==== design/requantizer.sv ====
`default_nettype none

`include "conv_cfg.svh"

// Stage 2 rounds half up, shifts arithmetically and clamps to int8
module requantizer (
    input  wire logic                      clk,
    input  wire logic                      arst_n,
    input  wire logic [`CONV_SHIFT_W-1:0]  shift,       // Sampled with the acc row
    acc_if.dst                             acc,
    output logic                           out_valid,
    output logic [`CONV_ROW_IDX_W-1:0]     out_row_idx,
    output conv_pkg::pix_row_t             out_data
);

    import conv_pkg::*;

    // Room for 2^(shift-1) at any shift plus a bit for the rounding add
    localparam int HALF_W = 2**`CONV_SHIFT_W;
    localparam int RQ_W   = ((`CONV_ACC_W > HALF_W) ? `CONV_ACC_W : HALF_W) + 1;

    localparam logic signed [RQ_W-1:0] PIX_MAX = 127;
    localparam logic signed [RQ_W-1:0] PIX_MIN = -128;

    pix_row_t pix;

    function automatic pix_t requant_lane(input acc_t a, input logic [`CONV_SHIFT_W-1:0] sh);
        logic signed [RQ_W-1:0] half;
        logic signed [RQ_W-1:0] rnd;
        logic signed [RQ_W-1:0] shf;
        half = '0;
        if (sh != '0) begin
            half[sh - 1'b1] = 1'b1;  // 2^(sh-1)
        end
        rnd = a + half;
        shf = rnd >>> sh;
        // Saturate
        if (shf > PIX_MAX) begin
            return pix_t'(PIX_MAX);
        end else if (shf < PIX_MIN) begin
            return pix_t'(PIX_MIN);
        end
        return pix_t'(shf);
    endfunction

    // Same rule in both modes
    always_comb begin
        for (int c = 0; c < `CONV_SA_ROWS; c++) begin
            for (int l = 0; l < `CONV_LANES; l++) begin
                pix[c][l] = requant_lane(acc.acc[c][l], shift);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= acc.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (acc.valid) begin
            out_row_idx <= acc.row_idx;
            out_data    <= pix;
        end
    end

endmodule

`default_nettype wire

// ==== design/conv_out_stage.sv ====
`default_nettype none

`include "conv_cfg.svh"

module conv_out_stage (
    input  wire logic                       clk,
    input  wire logic                       arst_n,

    // Bias tile load
    input  wire logic                       bias_set,      // One-cycle strobe
    input  wire logic [`CONV_TILE_W-1:0]    bias_tile_val,

    // Levels
    input  conv_pkg::mode_e                 mode,          // Sampled with psum
    input  wire logic [`CONV_SHIFT_W-1:0]   shift,         // Sampled one edge later

    // Partial sums from the core, one PE row per pulse
    input  wire logic                       psum_valid,
    input  wire logic [`CONV_ROW_IDX_W-1:0] psum_row_idx,
    input  conv_pkg::psum_row_t             psum_data,

    // Requantized row, two cycles after psum_valid
    output logic                            out_valid,
    output logic [`CONV_ROW_IDX_W-1:0]      out_row_idx,
    output conv_pkg::pix_row_t              out_data
);

    import conv_pkg::*;

    logic [`CONV_ROW_IDX_W-1:0] bias_idx;  // Align to bank
    bias_row_t                  bias_row;  // Bank to align, same cycle

    acc_if acc0 ();

    ////////////////////////////////////////////////////////////
    // Bias storage
    ////////////////////////////////////////////////////////////

    bias_bank bank0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .set      (bias_set),
        .tile_val (bias_tile_val),
        .row_idx  (bias_idx),
        .bias_row (bias_row)
    );

    ////////////////////////////////////////////////////////////
    // Two-stage pipeline
    ////////////////////////////////////////////////////////////

    bias_align align0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .psum_valid   (psum_valid),
        .psum_row_idx (psum_row_idx),
        .psum_data    (psum_data),
        .mode         (mode),
        .bias_idx     (bias_idx),
        .bias_row     (bias_row),
        .acc          (acc0.src)
    );

    requantizer requant0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .shift       (shift),
        .acc         (acc0.dst),
        .out_valid   (out_valid),
        .out_row_idx (out_row_idx),
        .out_data    (out_data)
    );

endmodule

`default_nettype wire

// ==== sim/conv_out_stage_sva.sv ====
`default_nettype none

`include "conv_cfg.svh"

// Latency and reset checks on the top-level ports
module conv_out_stage_sva (
    input wire logic                       clk,
    input wire logic                       arst_n,
    input wire logic                       psum_valid,
    input wire logic [`CONV_ROW_IDX_W-1:0] psum_row_idx,
    input wire logic                       out_valid,
    input wire logic [`CONV_ROW_IDX_W-1:0] out_row_idx
);

    ////////////////////////////////////////////////////////////
    // Two-cycle pipeline
    ////////////////////////////////////////////////////////////

    // Every accepted row leaves two edges later
    a_valid_latency: assert property (
        @(posedge clk) disable iff (!arst_n)
        psum_valid |-> ##2 out_valid
    ) else $error("psum_valid not followed by out_valid two cycles later");

    // No output without an input two edges back
    a_no_spurious: assert property (
        @(posedge clk) disable iff (!arst_n)
        out_valid |-> $past(psum_valid, 2)
    ) else $error("out_valid without psum_valid two cycles earlier");

    a_idx_follows: assert property (
        @(posedge clk) disable iff (!arst_n)
        out_valid |-> (out_row_idx == $past(psum_row_idx, 2))
    ) else $error("out_row_idx differs from psum_row_idx two cycles earlier");

    ////////////////////////////////////////////////////////////
    // Reset
    ////////////////////////////////////////////////////////////

    a_reset_quiet: assert property (
        @(posedge clk) !arst_n |-> !out_valid
    ) else $error("out_valid high during reset");

endmodule

`default_nettype wire

// ==== sim/conv_out_stage_tb.sv ====
`default_nettype none

`include "conv_cfg.svh"

module conv_out_stage_tb;

    import conv_pkg::*;

    localparam int IDX_W          = `CONV_ROW_IDX_W;
    localparam int DRAIN_CYCLES   = 24;   // Longest wait for the queue to empty

    logic                    clk;
    logic                    arst_n;
    logic                    bias_set;
    logic [`CONV_TILE_W-1:0] bias_tile_val;
    mode_e                   mode;
    logic [`CONV_SHIFT_W-1:0] shift;
    logic                    psum_valid;
    logic [IDX_W-1:0]        psum_row_idx;
    psum_row_t               psum_data;
    logic                    out_valid;
    logic [IDX_W-1:0]        out_row_idx;
    pix_row_t                out_data;

    logic [`CONV_TILE_W-1:0] tile_model;     // Tile as the bank should hold it
    logic [IDX_W-1:0]        exp_idx_q [$];  // Expected rows oldest first
    pix_row_t                exp_pix_q [$];
    string                   cur_test;
    int                      errors;
    int                      checks;

    conv_out_stage dut0 (
        .clk           (clk),
        .arst_n        (arst_n),
        .bias_set      (bias_set),
        .bias_tile_val (bias_tile_val),
        .mode          (mode),
        .shift         (shift),
        .psum_valid    (psum_valid),
        .psum_row_idx  (psum_row_idx),
        .psum_data     (psum_data),
        .out_valid     (out_valid),
        .out_row_idx   (out_row_idx),
        .out_data      (out_data)
    );

    bind conv_out_stage conv_out_stage_sva sva0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .psum_valid   (psum_valid),
        .psum_row_idx (psum_row_idx),
        .out_valid    (out_valid),
        .out_row_idx  (out_row_idx)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 unit period
    end

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_pix_row(input string name, input pix_row_t exp, input pix_row_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_row_idx(input string name, input logic [IDX_W-1:0] exp,
                                 input logic [IDX_W-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected row %0d, actual row %0d", name, exp, act);
        end
    endtask

    task automatic verify_valid(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected out_valid %b, actual %b", name, exp, act);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    // Channel-major tile holds set c*16 + (row-1)
    function automatic bias_set_u tile_set(input logic [`CONV_TILE_W-1:0] tile, input int c,
                                           input int row);
        return tile[(c*`CONV_PE_ROWS + row - 1)*`CONV_BIAS_SET_W +: `CONV_BIAS_SET_W];
    endfunction

    // Bias by mode, then round half up, shift and clamp to int8
    function automatic pix_row_t model_row(input psum_row_t p, input logic [IDX_W-1:0] idx,
                                           input mode_e m, input logic [`CONV_SHIFT_W-1:0] sh);
        pix_row_t  r;
        bias_set_u s;
        longint    b;
        longint    v;
        for (int c = 0; c < `CONV_SA_ROWS; c++) begin
            for (int l = 0; l < `CONV_LANES; l++) begin
                b = 0;                                  // Row 0 has no bias
                if (idx != 0 && idx <= `CONV_PE_ROWS) begin
                    s = tile_set(tile_model, c, int'(idx));
                    b = (m == MODE_88) ? longint'(s.bias88) : longint'(s.bias18[l]);
                end
                v = longint'(p[c][l]) + b;
                if (sh != 0) begin
                    v = (v + (longint'(1) << (sh - 1))) >>> sh;  // Floor after adding half
                end
                if (v > 127) begin
                    v = 127;
                end else if (v < -128) begin
                    v = -128;
                end
                r[c][l] = pix_t'(v);
            end
        end
        return r;
    endfunction

    ////////////////////////////////////////////////////////////
    // Stimulus and output monitor
    ////////////////////////////////////////////////////////////

    function automatic logic [`CONV_TILE_W-1:0] random_tile();
        logic [`CONV_TILE_W-1:0] t;
        for (int w = 0; w < `CONV_TILE_W/32; w++) begin
            t[w*32 +: 32] = $urandom;
        end
        return t;
    endfunction

    function automatic psum_row_t random_psums(input int span);
        psum_row_t p;
        for (int c = 0; c < `CONV_SA_ROWS; c++) begin
            for (int l = 0; l < `CONV_LANES; l++) begin
                p[c][l] = psum_t'(int'($urandom % (2*span + 1)) - span);  // -span..span
            end
        end
        return p;
    endfunction

    // One input cycle; a load on the same edge only reaches later rows
    task automatic drive_item(input logic [IDX_W-1:0] idx, input psum_row_t data,
                              input pix_row_t exp, input logic load,
                              input logic [`CONV_TILE_W-1:0] new_tile);
        exp_idx_q.push_back(idx);
        exp_pix_q.push_back(exp);
        psum_valid    = 1'b1;
        psum_row_idx  = idx;
        psum_data     = data;
        bias_set      = load;
        bias_tile_val = new_tile;
        @(posedge clk);
        #1;
        psum_valid = 1'b0;
        bias_set   = 1'b0;
        if (load) begin
            tile_model = new_tile;
        end
    endtask

    task automatic send_row(input int row, input psum_row_t data);
        drive_item(IDX_W'(row), data, model_row(data, IDX_W'(row), mode, shift), 1'b0, '0);
    endtask

    task automatic load_tile(input logic [`CONV_TILE_W-1:0] t);
        bias_set      = 1'b1;
        bias_tile_val = t;
        @(posedge clk);
        #1;
        bias_set   = 1'b0;
        tile_model = t;
    endtask

    // Bounded wait until every expected row came out
    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_pix_q.size() != 0 && cycles < DRAIN_CYCLES) begin
            @(negedge clk);
            #1;                                         // Let the monitor pop first
            cycles++;
        end
        if (exp_pix_q.size() != 0) begin
            errors++;
            $display("Timeout in %s: no output came for %0d pending rows within %0d cycles",
                     cur_test, exp_pix_q.size(), DRAIN_CYCLES);
            exp_pix_q.delete();
            exp_idx_q.delete();
        end
        @(posedge clk);
        #1;
    endtask

    // Outputs settle at posedge and are read half a cycle later
    always @(negedge clk) begin
        if (arst_n && out_valid) begin
            if (exp_pix_q.size() == 0) begin
                errors++;
                $display("Unexpected output in %s: row %0d came with nothing pending",
                         cur_test, out_row_idx);
            end else begin
                check_row_idx(cur_test, exp_idx_q.pop_front(), out_row_idx);
                check_pix_row(cur_test, exp_pix_q.pop_front(), out_data);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic reset_clears_tile();
        cur_test = "reset";
        mode  = MODE_88;
        shift = '0;
        load_tile(random_tile());                       // Something for reset to clear
        arst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        arst_n     = 1'b1;
        tile_model = '0;
        verify_valid(cur_test, 1'b0, out_valid);
        send_row(5, random_psums(100));                 // Cleared tile adds no bias
        wait_drain();
    endtask

    task automatic bias_shared_88();
        psum_row_t p;
        bias_set_u s;
        cur_test = "mode_88";
        mode     = MODE_88;
        shift    = '0;
        load_tile(random_tile());
        for (int row = 1; row <= `CONV_PE_ROWS; row++) begin
            p = random_psums(60);
            // Cancel the wide bias so the result stays inside int8
            for (int c = 0; c < `CONV_SA_ROWS; c++) begin
                s = tile_set(tile_model, c, row);
                for (int l = 0; l < `CONV_LANES; l++) begin
                    p[c][l] = p[c][l] - psum_t'(s.bias88);
                end
            end
            send_row(row, p);
        end
        wait_drain();
    endtask

    task automatic bias_split_18();
        cur_test = "mode_18";
        mode     = MODE_18;                             // Same tile read as a byte per lane
        shift    = '0;
        for (int row = 1; row <= `CONV_PE_ROWS; row++) begin
            send_row(row, random_psums(40));
        end
        wait_drain();
    endtask

    task automatic row_zero_passthrough();
        cur_test = "row_zero";
        shift    = '0;
        mode     = MODE_88;
        send_row(0, random_psums(100));
        mode     = MODE_18;
        send_row(0, random_psums(100));
        wait_drain();
    endtask

    task automatic round_and_saturate();
        psum_row_t p;
        pix_row_t  e;
        cur_test = "round_sat";
        mode     = MODE_88;
        shift    = 5'd4;                                // Divide by 16 with a half of 8
        p[0][0] = 24'sd8;        e[0][0] = 8'sd1;       // 0.5 rounds up
        p[0][1] = 24'sd7;        e[0][1] = 8'sd0;
        p[1][0] = -24'sd8;       e[1][0] = 8'sd0;       // -0.5 rounds up to 0
        p[1][1] = -24'sd9;       e[1][1] = -8'sd1;
        p[2][0] = 24'sd24;       e[2][0] = 8'sd2;       // 1.5 up to 2
        p[2][1] = 24'sd2040;     e[2][1] = 8'sd127;     // 128 clamps
        p[3][0] = 24'sh7FFFFF;   e[3][0] = 8'sd127;     // Largest psum
        p[3][1] = 24'sh800000;   e[3][1] = -8'sd128;    // Smallest psum
        drive_item('0, p, e, 1'b0, '0);
        send_row(1, p);                                 // Extremes plus a wide bias
        wait_drain();
    endtask

    task automatic stream_with_reload();
        logic [`CONV_TILE_W-1:0] next_tile;
        psum_row_t               p;
        cur_test  = "stream";
        mode      = MODE_18;
        shift     = 5'd2;
        next_tile = random_tile();
        for (int row = 1; row <= `CONV_PE_ROWS; row++) begin
            p = random_psums(400);
            // Load rides with row 8 so rows from 9 on see the new tile
            drive_item(IDX_W'(row), p, model_row(p, IDX_W'(row), mode, shift),
                       row == 8, next_tile);
        end
        wait_drain();
    endtask

    initial begin
        void'($urandom(96632));
        errors        = 0;
        checks        = 0;
        cur_test      = "init";
        tile_model    = '0;
        arst_n        = 1'b0;
        bias_set      = 1'b0;
        bias_tile_val = '0;
        mode          = MODE_88;
        shift         = '0;
        psum_valid    = 1'b0;
        psum_row_idx  = '0;
        psum_data     = '0;
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;

        reset_clears_tile();
        bias_shared_88();
        bias_split_18();
        row_zero_passthrough();
        round_and_saturate();
        stream_with_reload();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+design
design/conv_pkg.sv
design/acc_if.sv
design/bias_bank.sv
design/bias_align.sv
design/requantizer.sv
design/conv_out_stage.sv
sim/conv_out_stage_sva.sv
sim/conv_out_stage_tb.sv

// ==== Makefile ====
SIM  := obj_dir/Vconv_out_stage_tb
SRCS := $(wildcard design/*.sv design/*.svh sim/*.sv)

.PHONY: all run clean

all: run

$(SIM): files.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module conv_out_stage_tb -Mdir obj_dir \
		-o Vconv_out_stage_tb -f files.f

run: $(SIM)
	$(SIM) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "SIMULATION FAILED" sim.log \
		|| ! grep -q "SIMULATION PASSED" sim.log; then \
		echo "Run did not pass, see sim.log"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
